/* hdl/disk_consts.svh */
`ifndef DISK_CONSTS_SVH
`define DISK_CONSTS_SVH

// words in one block and in the block buffer
`define DISK_BUF_WORDS 128

// number of blocks in the backing store
// block offsets wrap modulo this count
`define DISK_NUM_BLOCKS 16

// cycles that ack stays high once raised
`define DISK_ACK_HOLD 7

// address bit choosing device region (1) or buffer region (0)
`define DISK_REGION_BIT 9

`endif

/* hdl/disk_bus_pkg.sv */
`default_nettype none

package disk_bus_pkg;

    // data word as seen on the bus and held in storage
    typedef logic [31:0] bus_word_t;

    // byte address, bits 8..2 index the buffer word
    typedef logic [31:0] bus_addr_t;

    // region picked by the region select bit
    typedef enum logic {
        REGION_BUFFER = 1'b0,
        REGION_DEVICE = 1'b1
    } bus_region_e;

endpackage

`default_nettype wire

/* hdl/disk_cmd_pkg.sv */
`default_nettype none

package disk_cmd_pkg;

    // transfer direction, taken from dat_i bit 31 of a device command
    typedef enum logic {
        DIR_FROM_DISK = 1'b0,
        DIR_TO_DISK   = 1'b1
    } disk_dir_e;

    // instruction word when it targets the disk
    typedef struct packed {
        logic        select;
        logic        write;
        logic        target;
        logic [28:0] offset;
    } disk_view_t;

    // instruction word when it targets the buffer
    typedef struct packed {
        logic        select;
        logic        write;
        logic        target;
        logic [21:0] unused;
        logic [6:0]  index;
    } buffer_view_t;

    typedef union packed {
        disk_view_t   disk;
        buffer_view_t buffer;
    } disk_instr_u;

endpackage

`default_nettype wire

/* hdl/disk_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface disk_if;
    import disk_bus_pkg::*;
    import disk_cmd_pkg::*;

    // bridge to unit
    disk_instr_u instr;
    bus_word_t   wdata;
    logic        write_start;
    logic        read_start;

    // unit to bridge
    bus_word_t   rdata;
    logic        done;

    modport bridge (
        output instr, wdata, write_start, read_start,
        input  rdata, done
    );

    // buffer drives rdata, store drives done
    modport unit (
        input  instr, wdata, write_start, read_start,
        output rdata, done
    );

endinterface

`default_nettype wire

/* hdl/disk_bus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "disk_consts.svh"

module disk_bus_bridge (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we,
    input  logic                    stb,
    input  disk_bus_pkg::bus_addr_t addr,
    input  disk_bus_pkg::bus_word_t dat_i,
    output logic                    ack,
    output disk_bus_pkg::bus_word_t dat_o,
    disk_if.bridge                  dev
);
    import disk_bus_pkg::*;
    import disk_cmd_pkg::*;

    logic        we_last;
    logic        we_pulse;
    logic        stb_last;
    logic        stb_rise;
    logic        ack_src;
    logic [2:0]  ack_cnt;
    bus_region_e region;
    disk_dir_e   dir;

    assign region   = bus_region_e'(addr[`DISK_REGION_BIT]);
    assign dir      = disk_dir_e'(dat_i[31]);
    assign stb_rise = stb & ~stb_last;

    // edge history of we and stb
    always_ff @(posedge clk) begin
        if (rst) begin
            we_last  <= 1'b0;
            we_pulse <= 1'b0;
            stb_last <= 1'b0;
        end else begin
            we_last  <= we;
            // single write pulse per access, one cycle after we rises
            we_pulse <= we & ~we_last;
            stb_last <= stb;
        end
    end

    // build the instruction in whichever view the region calls for
    always_comb begin
        dev.instr = '0;
        if (region == REGION_DEVICE) begin
            dev.instr.disk.select = stb;
            dev.instr.disk.write  = (dir == DIR_TO_DISK);
            dev.instr.disk.target = 1'b1;
            dev.instr.disk.offset = dat_i[28:0];
        end else begin
            dev.instr.buffer.select = stb;
            dev.instr.buffer.write  = we_pulse;
            dev.instr.buffer.target = 1'b0;
            dev.instr.buffer.index  = addr[8:2];
        end
    end

    assign dev.wdata = dat_i;
    assign dat_o     = dev.rdata;

    // start pulses on the rising edge of stb for device commands
    always_ff @(posedge clk) begin
        if (rst) begin
            dev.write_start <= 1'b0;
            dev.read_start  <= 1'b0;
        end else begin
            dev.write_start <= stb_rise && (region == REGION_DEVICE) && (dir == DIR_TO_DISK);
            dev.read_start  <= stb_rise && (region == REGION_DEVICE) && (dir == DIR_FROM_DISK);
        end
    end

    // buffer accesses finish at once, disk commands wait for done
    assign ack_src = (region == REGION_DEVICE) ? dev.done : stb;

    // hold counter keeps ack up long enough for a slow master
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_cnt <= '0;
        end else if (ack_cnt == '0) begin
            if (ack_src) begin
                ack_cnt <= 3'd1;
            end
        end else if (ack_cnt == 3'(`DISK_ACK_HOLD)) begin
            ack_cnt <= '0;
        end else begin
            ack_cnt <= ack_cnt + 3'd1;
        end
    end

    assign ack = (ack_cnt != '0);

endmodule

`default_nettype wire

/* hdl/disk_block_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "disk_consts.svh"

module disk_block_buffer (
    input  logic                    clk,
    disk_if.unit                    dev,
    input  logic [6:0]              xfer_index,
    input  logic                    xfer_we,
    input  disk_bus_pkg::bus_word_t xfer_wdata,
    output disk_bus_pkg::bus_word_t xfer_rdata
);
    import disk_bus_pkg::*;

    bus_word_t  mem [`DISK_BUF_WORDS];
    logic [6:0] bus_index;
    logic       bus_we;

    // bus side always reads the buffer view of the instruction
    assign bus_index = dev.instr.buffer.index;

    // write only for a selected buffer access with the write pulse set
    assign bus_we = dev.instr.buffer.select
                  & dev.instr.buffer.write
                  & ~dev.instr.buffer.target;

    // the two writers never overlap since the master
    // holds its device request for the whole transfer
    always_ff @(posedge clk) begin
        if (xfer_we) begin
            mem[xfer_index] <= xfer_wdata;
        end else if (bus_we) begin
            mem[bus_index] <= dev.wdata;
        end
    end

    // registered read toward the bus
    // valid from the second cycle of stb
    always_ff @(posedge clk) begin
        dev.rdata <= mem[bus_index];
    end

    // registered read toward the store
    always_ff @(posedge clk) begin
        xfer_rdata <= mem[xfer_index];
    end

endmodule

`default_nettype wire

/* hdl/disk_block_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "disk_consts.svh"

module disk_block_store (
    input  logic                    clk,
    input  logic                    rst,
    disk_if.unit                    dev,
    output logic [6:0]              xfer_index,
    output logic                    xfer_we,
    output disk_bus_pkg::bus_word_t xfer_wdata,
    input  disk_bus_pkg::bus_word_t xfer_rdata
);
    import disk_bus_pkg::*;
    import disk_cmd_pkg::*;

    localparam int BLK_W = $clog2(`DISK_NUM_BLOCKS);
    localparam int IDX_W = $clog2(`DISK_BUF_WORDS);
    localparam int LAST  = `DISK_BUF_WORDS + 1;

    bus_word_t                   mem [`DISK_NUM_BLOCKS * `DISK_BUF_WORDS];
    bus_word_t                   store_rdata;
    logic [`DISK_NUM_BLOCKS-1:0] blk_valid;
    logic                        busy;
    logic                        start;
    logic                        data_phase;
    disk_dir_e                   dir;
    logic [BLK_W-1:0]            block;
    logic [BLK_W-1:0]            start_block;
    logic [IDX_W:0]              cnt;
    logic [IDX_W-1:0]            rd_idx;
    logic [IDX_W-1:0]            wr_idx;

    assign start       = dev.write_start | dev.read_start;
    assign start_block = BLK_W'(dev.instr.disk.offset % `DISK_NUM_BLOCKS);

    // reads run one cycle ahead of writes on either side
    assign rd_idx     = cnt[IDX_W-1:0];
    assign wr_idx     = IDX_W'(cnt - 1'b1);
    assign data_phase = busy && (cnt != '0) && (cnt <= `DISK_BUF_WORDS);

    // sequencer: idle, then cnt 0..LAST, then done
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cnt       <= '0;
            dir       <= DIR_FROM_DISK;
            block     <= '0;
            blk_valid <= '0;
            dev.done  <= 1'b0;
        end else begin
            dev.done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy  <= 1'b1;
                    cnt   <= '0;
                    block <= start_block;
                    dir   <= dev.write_start ? DIR_TO_DISK : DIR_FROM_DISK;
                    if (dev.write_start) begin
                        blk_valid[start_block] <= 1'b1;
                    end
                end
            end else if (cnt == (IDX_W+1)'(LAST)) begin
                busy     <= 1'b0;
                dev.done <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // block storage, buffer words land one cycle after their read
    always_ff @(posedge clk) begin
        store_rdata <= mem[{block, rd_idx}];
        if (data_phase && dir == DIR_TO_DISK) begin
            mem[{block, wr_idx}] <= xfer_rdata;
        end
    end

    // a block never written reads as zeros
    assign xfer_wdata = blk_valid[block] ? store_rdata : '0;
    assign xfer_we    = data_phase && (dir == DIR_FROM_DISK);
    assign xfer_index = (dir == DIR_TO_DISK) ? rd_idx : wr_idx;

endmodule

`default_nettype wire

/* hdl/disk_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module disk_ctrl_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        we,
    input  logic        stb,
    input  logic [31:0] addr,
    input  logic [31:0] dat_i,
    output logic        ack,
    output logic [31:0] dat_o
);

    // transfer port between store and buffer
    logic [6:0]  xfer_index;
    logic        xfer_we;
    logic [31:0] xfer_wdata;
    logic [31:0] xfer_rdata;

    disk_if dev_if ();

    disk_bus_bridge bridge (
        .clk   (clk),
        .rst   (rst),
        .we    (we),
        .stb   (stb),
        .addr  (addr),
        .dat_i (dat_i),
        .ack   (ack),
        .dat_o (dat_o),
        .dev   (dev_if.bridge)
    );

    disk_block_buffer buffer_inst (
        .clk        (clk),
        .dev        (dev_if.unit),
        .xfer_index (xfer_index),
        .xfer_we    (xfer_we),
        .xfer_wdata (xfer_wdata),
        .xfer_rdata (xfer_rdata)
    );

    disk_block_store store_inst (
        .clk        (clk),
        .rst        (rst),
        .dev        (dev_if.unit),
        .xfer_index (xfer_index),
        .xfer_we    (xfer_we),
        .xfer_wdata (xfer_wdata),
        .xfer_rdata (xfer_rdata)
    );

endmodule

`default_nettype wire

/* testbench/disk_ctrl_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "disk_consts.svh"

module disk_ctrl_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    stb,
    input disk_bus_pkg::bus_addr_t addr,
    input logic                    ack,
    input logic                    write_start,
    input logic                    read_start,
    input logic                    done
);
    import disk_bus_pkg::*;

    int   fail_count = 0;
    logic dev_region;
    logic pending;

    assign dev_region = (bus_region_e'(addr[`DISK_REGION_BIT]) == REGION_DEVICE);

    // a disk command stays pending from its start pulse until done
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (write_start || read_start) begin
            pending <= 1'b1;
        end else if (done) begin
            pending <= 1'b0;
        end
    end

    // ack stays up for the whole hold stretch and then drops
    ack_hold: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> ack [*`DISK_ACK_HOLD] ##1 !ack)
        else begin
            $error("ack did not stay high for exactly the hold length");
            fail_count++;
        end

    // no new start pulse while a transfer is still running
    start_idle: assert property (@(posedge clk) disable iff (rst)
        (write_start || read_start) |-> !pending)
        else begin
            $error("start pulse while a transfer is still running");
            fail_count++;
        end

    // a start pulse needs a rising stb in the device region one cycle before
    start_cause: assert property (@(posedge clk) disable iff (rst)
        (write_start || read_start) |-> $past(stb) && !$past(stb, 2) && $past(dev_region))
        else begin
            $error("start pulse without a device region stb edge");
            fail_count++;
        end

endmodule

bind disk_bus_bridge disk_ctrl_checker checker_inst (
    .clk         (clk),
    .rst         (rst),
    .stb         (stb),
    .addr        (addr),
    .ack         (ack),
    .write_start (dev.write_start),
    .read_start  (dev.read_start),
    .done        (dev.done)
);

`default_nettype wire

/* testbench/disk_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "disk_consts.svh"

module disk_ctrl_tb;

    localparam int WORDS = `DISK_BUF_WORDS;
    // 15 buffer sweeps and 11 disk commands, with slack on each access
    localparam int TEST_CYCLES    = 15 * WORDS * 10 + 11 * (WORDS + 20);
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic        clk;
    logic        rst;
    logic        we;
    logic        stb;
    logic [31:0] addr;
    logic [31:0] dat_i;
    logic        ack;
    logic [31:0] dat_o;
    int          cycle_count = 0;

    // scoreboard for the buffer and the backing store
    logic [31:0] buf_model [WORDS];
    logic [31:0] store_model [`DISK_NUM_BLOCKS * WORDS];

    disk_ctrl_top disk_ctrl_top_inst (
        .clk   (clk),
        .rst   (rst),
        .we    (we),
        .stb   (stb),
        .addr  (addr),
        .dat_i (dat_i),
        .ack   (ack),
        .dat_o (dat_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_count);
            $display("test failed");
            $fatal(1, "run stopped by the cycle limit");
        end else if (disk_ctrl_top_inst.bridge.checker_inst.fail_count != 0) begin
            $display("the bridge checker reported an assertion failure");
            $display("test failed");
            $fatal(1, "run stopped by an assertion");
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one bus access, held until ack, then wait for ack to fall
    task automatic bus_access(input logic write, input logic [31:0] a,
                              input logic [31:0] d, output logic [31:0] rd);
        int ack_len;
        ack_len = 0;
        we      = write;
        stb     = 1'b1;
        addr    = a;
        dat_i   = d;
        do begin
            next_cycle();
        end while (!ack);
        rd = dat_o;
        // slow master lets go of stb one cycle into ack
        while (ack) begin
            ack_len++;
            next_cycle();
            if (ack_len == 1) begin
                stb = 1'b0;
                we  = 1'b0;
            end
        end
        check_equal(32'(ack_len), `DISK_ACK_HOLD, "ack length");
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        logic [31:0] unused;
        bus_access(1'b1, a, d, unused);
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        bus_access(1'b0, a, 32'h0, d);
    endtask

    task automatic disk_cmd(input logic to_disk, input int offset);
        int base;
        bus_write(32'd1 << `DISK_REGION_BIT, {to_disk, 2'b00, 29'(offset)});
        base = (offset % `DISK_NUM_BLOCKS) * WORDS;
        for (int i = 0; i < WORDS; i++) begin
            if (to_disk) begin
                store_model[base + i] = buf_model[i];
            end else begin
                buf_model[i] = store_model[base + i];
            end
        end
    endtask

    task automatic fill_buffer();
        logic [31:0] d;
        for (int i = 0; i < WORDS; i++) begin
            d = $urandom();
            bus_write(32'(i) << 2, d);
            buf_model[i] = d;
        end
    endtask

    task automatic verify_buffer(input string what);
        logic [31:0] d;
        for (int i = 0; i < WORDS; i++) begin
            bus_read(32'(i) << 2, d);
            check_equal(d, buf_model[i], $sformatf("%s word %0d", what, i));
        end
    endtask

    task automatic test_reset_idle();
        repeat (10) begin
            next_cycle();
            check_equal(32'(ack), 32'h0, "ack while idle");
        end
    endtask

    task automatic test_store_load();
        fill_buffer();
        disk_cmd(1'b1, 3);
        fill_buffer();
        disk_cmd(1'b0, 3);
        verify_buffer("block 3 reload");
    endtask

    task automatic test_multi_block();
        int store_order [3] = '{0, 7, 15};
        int load_order [3]  = '{15, 0, 7};
        foreach (store_order[k]) begin
            fill_buffer();
            disk_cmd(1'b1, store_order[k]);
        end
        foreach (load_order[k]) begin
            disk_cmd(1'b0, load_order[k]);
            verify_buffer($sformatf("block %0d", load_order[k]));
        end
    endtask

    // offset 19 lands on the same block as offset 3
    task automatic test_offset_wrap();
        fill_buffer();
        disk_cmd(1'b1, 19);
        fill_buffer();
        disk_cmd(1'b0, 3);
        verify_buffer("wrapped offset");
    endtask

    task automatic test_unwritten_block();
        logic [31:0] d;
        disk_cmd(1'b0, 9);
        for (int i = 0; i < WORDS; i++) begin
            bus_read(32'(i) << 2, d);
            check_equal(d, 32'h0, $sformatf("unwritten block word %0d", i));
        end
    endtask

    initial begin
        clk = 1'b0;
        void'($urandom(32'h375e127a));
        rst   = 1'b1;
        we    = 1'b0;
        stb   = 1'b0;
        addr  = '0;
        dat_i = '0;
        foreach (store_model[i]) begin
            store_model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_idle();
        fill_buffer();
        verify_buffer("buffer readback");
        test_store_load();
        test_multi_block();
        test_offset_wrap();
        test_unwritten_block();

        if (disk_ctrl_top_inst.bridge.checker_inst.fail_count != 0) begin
            $display("the bridge checker reported an assertion failure");
            $display("test failed");
            $fatal(1, "run ended with assertion failures");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* disk_ctrl_top.f */
+incdir+hdl
hdl/disk_bus_pkg.sv
hdl/disk_cmd_pkg.sv
hdl/disk_if.sv
hdl/disk_bus_bridge.sv
hdl/disk_block_buffer.sv
hdl/disk_block_store.sv
hdl/disk_ctrl_top.sv
testbench/disk_ctrl_checker.sv
testbench/disk_ctrl_tb.sv
